/* hdl/ip_switch_pkg.sv */
package ip_switch_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = 8;

    // IP protocol numbers handled internally
    localparam logic [7:0] PROTO_UDP  = 8'h11;
    localparam logic [7:0] PROTO_ICMP = 8'h01;

    // APB register map, byte addresses
    localparam logic [7:0] ADDR_CTRL      = 8'h00;
    localparam logic [7:0] ADDR_CNT_UDP   = 8'h04;
    localparam logic [7:0] ADDR_CNT_ICMP  = 8'h08;
    localparam logic [7:0] ADDR_CNT_OTHER = 8'h0C;
    localparam logic [7:0] ADDR_CNT_DROP  = 8'h10;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
    } ip_beat_t;

    // Also the bit index into route_en
    typedef enum logic [1:0] {
        ROUTE_UDP   = 2'd0,
        ROUTE_ICMP  = 2'd1,
        ROUTE_OTHER = 2'd2
    } route_t;

    typedef struct packed {
        logic   valid;
        route_t route;
        logic   dropped;
    } rx_event_t;

    typedef enum logic [1:0] {ST_IDLE, ST_FORWARD, ST_DROP} demux_state_t;

    typedef enum logic {ARB_IDLE, ARB_FRAME} arb_state_t;

endpackage

/* hdl/ip_rx_demux.sv */
`timescale 1ns/1ps

module ip_rx_demux
    import ip_switch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic [2:0] route_en,

    input  logic      rx_in_hdr_valid,
    input  ip_hdr_t   rx_in_hdr,
    output logic      rx_in_hdr_ready,
    input  logic      rx_in_pay_valid,
    input  ip_beat_t  rx_in_pay,
    output logic      rx_in_pay_ready,

    output logic      udp_hdr_valid,
    output ip_hdr_t   udp_hdr,
    input  logic      udp_hdr_ready,
    output logic      udp_pay_valid,
    output ip_beat_t  udp_pay,
    input  logic      udp_pay_ready,

    output logic      icmp_hdr_valid,
    output ip_hdr_t   icmp_hdr,
    input  logic      icmp_hdr_ready,
    output logic      icmp_pay_valid,
    output ip_beat_t  icmp_pay,
    input  logic      icmp_pay_ready,

    output logic      other_hdr_valid,
    output ip_hdr_t   other_hdr,
    input  logic      other_hdr_ready,
    output logic      other_pay_valid,
    output ip_beat_t  other_pay,
    input  logic      other_pay_ready,

    output rx_event_t rx_event
);

    demux_state_t state;
    route_t       route_q;
    route_t       sel_route;
    logic         sel_en;
    logic         hdr_fire;
    logic         last_fire;
    logic [2:0]   hdr_valid_o;
    logic [2:0]   pay_valid_o;
    logic [2:0]   hdr_ready_i;
    logic [2:0]   pay_ready_i;

    // Classify on the protocol field
    always_comb begin
        if (rx_in_hdr.protocol == PROTO_UDP) begin
            sel_route = ROUTE_UDP;
        end else if (rx_in_hdr.protocol == PROTO_ICMP) begin
            sel_route = ROUTE_ICMP;
        end else begin
            sel_route = ROUTE_OTHER;
        end
    end

    assign sel_en      = route_en[sel_route];
    assign hdr_ready_i = {other_hdr_ready, icmp_hdr_ready, udp_hdr_ready};
    assign pay_ready_i = {other_pay_ready, icmp_pay_ready, udp_pay_ready};

    always_comb begin
        hdr_valid_o     = '0;
        pay_valid_o     = '0;
        rx_in_hdr_ready = 1'b0;
        rx_in_pay_ready = 1'b0;
        case (state)
            ST_IDLE: begin
                hdr_valid_o[sel_route] = rx_in_hdr_valid && sel_en;
                // Disabled route swallows the header
                rx_in_hdr_ready = sel_en ? hdr_ready_i[sel_route] : 1'b1;
            end
            ST_FORWARD: begin
                pay_valid_o[route_q] = rx_in_pay_valid;
                rx_in_pay_ready      = pay_ready_i[route_q];
            end
            ST_DROP: begin
                rx_in_pay_ready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign hdr_fire  = rx_in_hdr_valid && rx_in_hdr_ready;
    assign last_fire = rx_in_pay_valid && rx_in_pay_ready && rx_in_pay.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            route_q <= ROUTE_UDP;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        route_q <= sel_route;
                        if (sel_en) begin
                            state <= ST_FORWARD;
                        end else begin
                            state <= ST_DROP;
                        end
                    end
                end
                default: begin
                    if (last_fire) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    assign udp_hdr_valid   = hdr_valid_o[ROUTE_UDP];
    assign icmp_hdr_valid  = hdr_valid_o[ROUTE_ICMP];
    assign other_hdr_valid = hdr_valid_o[ROUTE_OTHER];
    assign udp_pay_valid   = pay_valid_o[ROUTE_UDP];
    assign icmp_pay_valid  = pay_valid_o[ROUTE_ICMP];
    assign other_pay_valid = pay_valid_o[ROUTE_OTHER];

    // Data fans out, only the valids are steered
    assign udp_hdr   = rx_in_hdr;
    assign icmp_hdr  = rx_in_hdr;
    assign other_hdr = rx_in_hdr;
    assign udp_pay   = rx_in_pay;
    assign icmp_pay  = rx_in_pay;
    assign other_pay = rx_in_pay;

    assign rx_event = '{valid: hdr_fire, route: sel_route, dropped: !sel_en};

endmodule

/* hdl/ip_tx_arbiter.sv */
`timescale 1ns/1ps

module ip_tx_arbiter
    import ip_switch_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     icmp_hdr_valid,
    input  ip_hdr_t  icmp_hdr,
    output logic     icmp_hdr_ready,
    input  logic     icmp_pay_valid,
    input  ip_beat_t icmp_pay,
    output logic     icmp_pay_ready,

    input  logic     udp_hdr_valid,
    input  ip_hdr_t  udp_hdr,
    output logic     udp_hdr_ready,
    input  logic     udp_pay_valid,
    input  ip_beat_t udp_pay,
    output logic     udp_pay_ready,

    input  logic     other_hdr_valid,
    input  ip_hdr_t  other_hdr,
    output logic     other_hdr_ready,
    input  logic     other_pay_valid,
    input  ip_beat_t other_pay,
    output logic     other_pay_ready,

    output logic     out_hdr_valid,
    output ip_hdr_t  out_hdr,
    input  logic     out_hdr_ready,
    output logic     out_pay_valid,
    output ip_beat_t out_pay,
    input  logic     out_pay_ready
);

    // Source 0 is ICMP, the highest priority
    ip_hdr_t    src_hdr [3];
    ip_beat_t   src_pay [3];
    logic [2:0] src_hdr_valid;
    logic [2:0] src_pay_valid;
    logic [2:0] src_hdr_ready;
    logic [2:0] src_pay_ready;
    logic [1:0] sel;
    logic [1:0] grant_q;
    arb_state_t state;

    assign src_hdr       = '{icmp_hdr, udp_hdr, other_hdr};
    assign src_pay       = '{icmp_pay, udp_pay, other_pay};
    assign src_hdr_valid = {other_hdr_valid, udp_hdr_valid, icmp_hdr_valid};
    assign src_pay_valid = {other_pay_valid, udp_pay_valid, icmp_pay_valid};

    always_comb begin
        if (src_hdr_valid[0]) begin
            sel = 2'd0;
        end else if (src_hdr_valid[1]) begin
            sel = 2'd1;
        end else begin
            sel = 2'd2;
        end
    end

    always_comb begin
        out_hdr_valid = 1'b0;
        out_pay_valid = 1'b0;
        src_hdr_ready = '0;
        src_pay_ready = '0;
        if (state == ARB_IDLE) begin
            out_hdr_valid      = |src_hdr_valid;
            src_hdr_ready[sel] = out_hdr_ready;
        end else begin
            out_pay_valid          = src_pay_valid[grant_q];
            src_pay_ready[grant_q] = out_pay_ready;
        end
    end

    assign out_hdr = src_hdr[sel];
    assign out_pay = src_pay[grant_q];

    // Grant held until the last beat of the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ARB_IDLE;
            grant_q <= 2'd0;
        end else if (state == ARB_IDLE) begin
            if (out_hdr_valid && out_hdr_ready) begin
                grant_q <= sel;
                state   <= ARB_FRAME;
            end
        end else if (out_pay_valid && out_pay_ready && out_pay.last) begin
            state <= ARB_IDLE;
        end
    end

    assign icmp_hdr_ready  = src_hdr_ready[0];
    assign udp_hdr_ready   = src_hdr_ready[1];
    assign other_hdr_ready = src_hdr_ready[2];
    assign icmp_pay_ready  = src_pay_ready[0];
    assign udp_pay_ready   = src_pay_ready[1];
    assign other_pay_ready = src_pay_ready[2];

endmodule

/* hdl/ip_switch_regs.sv */
`timescale 1ns/1ps

module ip_switch_regs
    import ip_switch_pkg::*;
#(
    parameter int COUNT_WIDTH = 32
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    input  rx_event_t   rx_event,
    output logic [2:0]  route_en
);

    logic [COUNT_WIDTH-1:0] cnt_udp;
    logic [COUNT_WIDTH-1:0] cnt_icmp;
    logic [COUNT_WIDTH-1:0] cnt_other;
    logic [COUNT_WIDTH-1:0] cnt_drop;
    logic                   apb_access;
    logic                   apb_wr;
    logic                   mapped;
    logic [31:0]            rdata;

    assign apb_access = psel && penable;
    assign apb_wr     = apb_access && pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            route_en  <= 3'b111;
            cnt_udp   <= '0;
            cnt_icmp  <= '0;
            cnt_other <= '0;
            cnt_drop  <= '0;
        end else begin
            if (apb_wr && paddr == ADDR_CTRL) begin
                route_en <= pwdata[2:0];
            end
            // Dropped frames count only as drops
            if (rx_event.valid) begin
                if (rx_event.dropped) begin
                    cnt_drop <= cnt_drop + 1'b1;
                end else begin
                    case (rx_event.route)
                        ROUTE_UDP:  cnt_udp  <= cnt_udp + 1'b1;
                        ROUTE_ICMP: cnt_icmp <= cnt_icmp + 1'b1;
                        default:    cnt_other <= cnt_other + 1'b1;
                    endcase
                end
            end
        end
    end

    always_comb begin
        rdata  = '0;
        mapped = 1'b1;
        case (paddr)
            ADDR_CTRL:      rdata = {29'd0, route_en};
            ADDR_CNT_UDP:   rdata = 32'(cnt_udp);
            ADDR_CNT_ICMP:  rdata = 32'(cnt_icmp);
            ADDR_CNT_OTHER: rdata = 32'(cnt_other);
            ADDR_CNT_DROP:  rdata = 32'(cnt_drop);
            default:        mapped = 1'b0;
        endcase
    end

    // Counters are read only
    assign pslverr = apb_access && (!mapped || (pwrite && paddr != ADDR_CTRL));
    assign prdata  = pwrite ? 32'd0 : rdata;
    assign pready  = 1'b1;

endmodule

/* hdl/ip_proto_switch.sv */
`timescale 1ns/1ps

module ip_proto_switch
    import ip_switch_pkg::*;
#(
    parameter int COUNT_WIDTH = 32
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    // Receive side, from the IP stack
    input  logic        rx_in_hdr_valid,
    input  ip_hdr_t     rx_in_hdr,
    output logic        rx_in_hdr_ready,
    input  logic        rx_in_pay_valid,
    input  ip_beat_t    rx_in_pay,
    output logic        rx_in_pay_ready,

    output logic        rx_udp_hdr_valid,
    output ip_hdr_t     rx_udp_hdr,
    input  logic        rx_udp_hdr_ready,
    output logic        rx_udp_pay_valid,
    output ip_beat_t    rx_udp_pay,
    input  logic        rx_udp_pay_ready,

    output logic        rx_icmp_hdr_valid,
    output ip_hdr_t     rx_icmp_hdr,
    input  logic        rx_icmp_hdr_ready,
    output logic        rx_icmp_pay_valid,
    output ip_beat_t    rx_icmp_pay,
    input  logic        rx_icmp_pay_ready,

    output logic        rx_other_hdr_valid,
    output ip_hdr_t     rx_other_hdr,
    input  logic        rx_other_hdr_ready,
    output logic        rx_other_pay_valid,
    output ip_beat_t    rx_other_pay,
    input  logic        rx_other_pay_ready,

    // Transmit side, toward the IP stack
    input  logic        tx_udp_hdr_valid,
    input  ip_hdr_t     tx_udp_hdr,
    output logic        tx_udp_hdr_ready,
    input  logic        tx_udp_pay_valid,
    input  ip_beat_t    tx_udp_pay,
    output logic        tx_udp_pay_ready,

    input  logic        tx_icmp_hdr_valid,
    input  ip_hdr_t     tx_icmp_hdr,
    output logic        tx_icmp_hdr_ready,
    input  logic        tx_icmp_pay_valid,
    input  ip_beat_t    tx_icmp_pay,
    output logic        tx_icmp_pay_ready,

    input  logic        tx_other_hdr_valid,
    input  ip_hdr_t     tx_other_hdr,
    output logic        tx_other_hdr_ready,
    input  logic        tx_other_pay_valid,
    input  ip_beat_t    tx_other_pay,
    output logic        tx_other_pay_ready,

    output logic        tx_out_hdr_valid,
    output ip_hdr_t     tx_out_hdr,
    input  logic        tx_out_hdr_ready,
    output logic        tx_out_pay_valid,
    output ip_beat_t    tx_out_pay,
    input  logic        tx_out_pay_ready
);

    logic [2:0] route_en;
    rx_event_t  rx_event;

    ip_rx_demux ip_rx_demux_inst (
        .clk             (clk),
        .rst             (rst),
        .route_en        (route_en),
        .rx_in_hdr_valid (rx_in_hdr_valid),
        .rx_in_hdr       (rx_in_hdr),
        .rx_in_hdr_ready (rx_in_hdr_ready),
        .rx_in_pay_valid (rx_in_pay_valid),
        .rx_in_pay       (rx_in_pay),
        .rx_in_pay_ready (rx_in_pay_ready),
        .udp_hdr_valid   (rx_udp_hdr_valid),
        .udp_hdr         (rx_udp_hdr),
        .udp_hdr_ready   (rx_udp_hdr_ready),
        .udp_pay_valid   (rx_udp_pay_valid),
        .udp_pay         (rx_udp_pay),
        .udp_pay_ready   (rx_udp_pay_ready),
        .icmp_hdr_valid  (rx_icmp_hdr_valid),
        .icmp_hdr        (rx_icmp_hdr),
        .icmp_hdr_ready  (rx_icmp_hdr_ready),
        .icmp_pay_valid  (rx_icmp_pay_valid),
        .icmp_pay        (rx_icmp_pay),
        .icmp_pay_ready  (rx_icmp_pay_ready),
        .other_hdr_valid (rx_other_hdr_valid),
        .other_hdr       (rx_other_hdr),
        .other_hdr_ready (rx_other_hdr_ready),
        .other_pay_valid (rx_other_pay_valid),
        .other_pay       (rx_other_pay),
        .other_pay_ready (rx_other_pay_ready),
        .rx_event        (rx_event)
    );

    ip_tx_arbiter ip_tx_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .icmp_hdr_valid  (tx_icmp_hdr_valid),
        .icmp_hdr        (tx_icmp_hdr),
        .icmp_hdr_ready  (tx_icmp_hdr_ready),
        .icmp_pay_valid  (tx_icmp_pay_valid),
        .icmp_pay        (tx_icmp_pay),
        .icmp_pay_ready  (tx_icmp_pay_ready),
        .udp_hdr_valid   (tx_udp_hdr_valid),
        .udp_hdr         (tx_udp_hdr),
        .udp_hdr_ready   (tx_udp_hdr_ready),
        .udp_pay_valid   (tx_udp_pay_valid),
        .udp_pay         (tx_udp_pay),
        .udp_pay_ready   (tx_udp_pay_ready),
        .other_hdr_valid (tx_other_hdr_valid),
        .other_hdr       (tx_other_hdr),
        .other_hdr_ready (tx_other_hdr_ready),
        .other_pay_valid (tx_other_pay_valid),
        .other_pay       (tx_other_pay),
        .other_pay_ready (tx_other_pay_ready),
        .out_hdr_valid   (tx_out_hdr_valid),
        .out_hdr         (tx_out_hdr),
        .out_hdr_ready   (tx_out_hdr_ready),
        .out_pay_valid   (tx_out_pay_valid),
        .out_pay         (tx_out_pay),
        .out_pay_ready   (tx_out_pay_ready)
    );

    ip_switch_regs #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) ip_switch_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .rx_event (rx_event),
        .route_en (route_en)
    );

endmodule

/* verification/tb_frames.svh */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// Each row holds protocol, IP length, source IP, beat count, data seed,
// expected route and whether that route is enabled while the frame is sent
localparam int N_FRAMES = 12;

localparam frame_t FRAMES [N_FRAMES] = '{
    '{8'h11, 16'd44, 32'hc0a8_0a01, 2'd2, 32'h0000_3c11, ROUTE_UDP,   1'b1},
    '{8'h01, 16'd28, 32'hc0a8_0a02, 2'd1, 32'h0001_4001, ROUTE_ICMP,  1'b1},
    '{8'h06, 16'd60, 32'h0a00_0005, 2'd3, 32'h0002_8006, ROUTE_OTHER, 1'b1},
    '{8'h11, 16'd52, 32'hc0a8_0a03, 2'd3, 32'h0003_2211, ROUTE_UDP,   1'b1},
    // UDP, then ICMP switched off
    '{8'h11, 16'd36, 32'hac10_0001, 2'd2, 32'h0004_7711, ROUTE_UDP,   1'b0},
    '{8'h01, 16'd48, 32'hac10_0002, 2'd3, 32'h0005_0901, ROUTE_ICMP,  1'b0},
    '{8'h2f, 16'd24, 32'h0a00_0009, 2'd1, 32'h0006_a12f, ROUTE_OTHER, 1'b1},
    '{8'h06, 16'd40, 32'h0a00_000a, 2'd2, 32'h0007_5506, ROUTE_OTHER, 1'b0},
    '{8'h11, 16'd28, 32'hc0a8_0a04, 2'd1, 32'h0008_1f11, ROUTE_UDP,   1'b1},
    '{8'h01, 16'd36, 32'hc0a8_0a05, 2'd2, 32'h0009_c301, ROUTE_ICMP,  1'b1},
    '{8'h11, 16'd28, 32'hac10_0003, 2'd1, 32'h000a_6e11, ROUTE_UDP,   1'b0},
    '{8'h84, 16'd60, 32'h0a00_000b, 2'd3, 32'h000b_e884, ROUTE_OTHER, 1'b1}
};

`endif

/* verification/ip_proto_switch_tb.sv */
`timescale 1ns/1ps

module ip_proto_switch_tb
    import ip_switch_pkg::*;
();

    localparam logic [31:0] SEED   = 32'hda34_1a02;
    localparam logic [31:0] TX_MIX = 32'h0000_7e7e;

    typedef struct packed {
        logic [7:0]  proto;
        logic [15:0] length;
        logic [31:0] src;
        logic [1:0]  beats;
        logic [31:0] seed;
        route_t      route;
        logic        en;
    } frame_t;

    // One expected transfer on one sink
    typedef struct packed {
        logic [1:0] sink;
        logic       is_hdr;
        ip_hdr_t    hdr;
        ip_beat_t   beat;
    } item_t;

    `include "tb_frames.svh"

    localparam int MAX_CYCLES = 40 * N_FRAMES + 200;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Sources 0 to 2 are tx icmp, udp, other and source 3 is rx_in
    logic     src_hdr_valid [4];
    ip_hdr_t  src_hdr [4];
    logic     src_hdr_ready [4];
    logic     src_pay_valid [4];
    ip_beat_t src_pay [4];
    logic     src_pay_ready [4];

    // Sinks 0 to 2 follow route_t and sink 3 is tx_out
    logic     snk_hdr_valid [4];
    ip_hdr_t  snk_hdr [4];
    logic     snk_hdr_ready [4];
    logic     snk_pay_valid [4];
    ip_beat_t snk_pay [4];
    logic     snk_pay_ready [4];

    item_t       expected [$];
    logic        bp_on;
    logic [31:0] rnd_q;
    int          cycles;
    int          errors;
    int          exp_cnt [4];
    string       sink_name [4] = '{"rx_udp", "rx_icmp", "rx_other", "tx_out"};
    string       cnt_name [4] = '{"cnt_udp", "cnt_icmp", "cnt_other", "cnt_drop"};
    logic [7:0]  cnt_addr [4] = '{ADDR_CNT_UDP, ADDR_CNT_ICMP, ADDR_CNT_OTHER, ADDR_CNT_DROP};

    ip_proto_switch #(
        .COUNT_WIDTH (32)
    ) ip_proto_switch_inst (
        .clk                (clk),
        .rst                (rst),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr),
        .rx_in_hdr_valid    (src_hdr_valid[3]),
        .rx_in_hdr          (src_hdr[3]),
        .rx_in_hdr_ready    (src_hdr_ready[3]),
        .rx_in_pay_valid    (src_pay_valid[3]),
        .rx_in_pay          (src_pay[3]),
        .rx_in_pay_ready    (src_pay_ready[3]),
        .rx_udp_hdr_valid   (snk_hdr_valid[0]),
        .rx_udp_hdr         (snk_hdr[0]),
        .rx_udp_hdr_ready   (snk_hdr_ready[0]),
        .rx_udp_pay_valid   (snk_pay_valid[0]),
        .rx_udp_pay         (snk_pay[0]),
        .rx_udp_pay_ready   (snk_pay_ready[0]),
        .rx_icmp_hdr_valid  (snk_hdr_valid[1]),
        .rx_icmp_hdr        (snk_hdr[1]),
        .rx_icmp_hdr_ready  (snk_hdr_ready[1]),
        .rx_icmp_pay_valid  (snk_pay_valid[1]),
        .rx_icmp_pay        (snk_pay[1]),
        .rx_icmp_pay_ready  (snk_pay_ready[1]),
        .rx_other_hdr_valid (snk_hdr_valid[2]),
        .rx_other_hdr       (snk_hdr[2]),
        .rx_other_hdr_ready (snk_hdr_ready[2]),
        .rx_other_pay_valid (snk_pay_valid[2]),
        .rx_other_pay       (snk_pay[2]),
        .rx_other_pay_ready (snk_pay_ready[2]),
        .tx_icmp_hdr_valid  (src_hdr_valid[0]),
        .tx_icmp_hdr        (src_hdr[0]),
        .tx_icmp_hdr_ready  (src_hdr_ready[0]),
        .tx_icmp_pay_valid  (src_pay_valid[0]),
        .tx_icmp_pay        (src_pay[0]),
        .tx_icmp_pay_ready  (src_pay_ready[0]),
        .tx_udp_hdr_valid   (src_hdr_valid[1]),
        .tx_udp_hdr         (src_hdr[1]),
        .tx_udp_hdr_ready   (src_hdr_ready[1]),
        .tx_udp_pay_valid   (src_pay_valid[1]),
        .tx_udp_pay         (src_pay[1]),
        .tx_udp_pay_ready   (src_pay_ready[1]),
        .tx_other_hdr_valid (src_hdr_valid[2]),
        .tx_other_hdr       (src_hdr[2]),
        .tx_other_hdr_ready (src_hdr_ready[2]),
        .tx_other_pay_valid (src_pay_valid[2]),
        .tx_other_pay       (src_pay[2]),
        .tx_other_pay_ready (src_pay_ready[2]),
        .tx_out_hdr_valid   (snk_hdr_valid[3]),
        .tx_out_hdr         (snk_hdr[3]),
        .tx_out_hdr_ready   (snk_hdr_ready[3]),
        .tx_out_pay_valid   (snk_pay_valid[3]),
        .tx_out_pay         (snk_pay[3]),
        .tx_out_pay_ready   (snk_pay_ready[3])
    );

    always #20 clk = ~clk;

    // Random back-pressure on rx_udp payload and on tx_out
    assign snk_hdr_ready[0] = 1'b1;
    assign snk_hdr_ready[1] = 1'b1;
    assign snk_hdr_ready[2] = 1'b1;
    assign snk_pay_ready[0] = !bp_on || rnd_q[16];
    assign snk_pay_ready[1] = 1'b1;
    assign snk_pay_ready[2] = 1'b1;
    assign snk_hdr_ready[3] = !bp_on || rnd_q[17];
    assign snk_pay_ready[3] = !bp_on || rnd_q[18];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rnd_q <= SEED;
        end else begin
            rnd_q <= lcg_next(rnd_q);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic ip_hdr_t build_hdr(input frame_t f);
        ip_hdr_t h;
        h.dscp      = f.seed[5:0];
        h.ecn       = f.seed[7:6];
        h.length    = f.length;
        h.ttl       = f.seed[15:8];
        h.protocol  = f.proto;
        h.source_ip = f.src;
        h.dest_ip   = ~f.src;
        return h;
    endfunction

    // Two LCG steps per beat from the global seed mixed with the frame seed
    function automatic ip_beat_t build_beat(input logic [31:0] seed, input int i, input int n);
        logic [31:0] s;
        ip_beat_t    b;
        s = SEED ^ seed;
        for (int k = 0; k <= 2 * i; k++) begin
            s = lcg_next(s);
        end
        b.data[63:32] = s;
        s = lcg_next(s);
        b.data[31:0] = s;
        b.last = (i == n - 1);
        b.keep = b.last ? (8'hff >> s[2:0]) : 8'hff;
        b.user = s[31];
        return b;
    endfunction

    task automatic report_mismatch(input string name, input logic [159:0] exp,
                                   input logic [159:0] got);
        errors++;
        $display("FAILED t=%0t %s: expected %0h, got %0h", $time, name, exp, got);
    endtask

    task automatic expect_frame(input int k, input frame_t f, input logic [31:0] seed);
        item_t it;
        int    n;
        n         = int'(f.beats);
        it        = '0;
        it.sink   = 2'(k);
        it.is_hdr = 1'b1;
        it.hdr    = build_hdr(f);
        expected.push_back(it);
        for (int i = 0; i < n; i++) begin
            it      = '0;
            it.sink = 2'(k);
            it.beat = build_beat(seed, i, n);
            expected.push_back(it);
        end
    endtask

    task automatic take_item(input int k, input logic is_hdr, input ip_hdr_t h,
                             input ip_beat_t b);
        item_t it;
        if (expected.size() == 0) begin
            errors++;
            $display("Unexpected transfer on %s at %0t", sink_name[k], $time);
        end else begin
            it = expected.pop_front();
            if (it.sink != 2'(k) || it.is_hdr != is_hdr) begin
                errors++;
                $display("Transfer on %s at %0t, but the next one was due on %s",
                         sink_name[k], $time, sink_name[it.sink]);
            end else if (is_hdr && h !== it.hdr) begin
                report_mismatch({sink_name[k], "_hdr"}, 160'(it.hdr), 160'(h));
            end else if (!is_hdr && b !== it.beat) begin
                report_mismatch({sink_name[k], "_pay"}, 160'(it.beat), 160'(b));
            end
        end
    endtask

    // Handshakes are stable at the falling edge
    task automatic watch_sinks();
        forever begin
            @(negedge clk);
            for (int k = 0; k < 4; k++) begin
                if (!rst && snk_hdr_valid[k] && snk_hdr_ready[k]) begin
                    take_item(k, 1'b1, snk_hdr[k], '0);
                end
                if (!rst && snk_pay_valid[k] && snk_pay_ready[k]) begin
                    take_item(k, 1'b0, '0, snk_pay[k]);
                end
            end
        end
    endtask

    task automatic send_frame(input int s, input frame_t f, input logic [31:0] seed);
        int n;
        n = int'(f.beats);
        @(posedge clk);
        src_hdr_valid[s] <= 1'b1;
        src_hdr[s]       <= build_hdr(f);
        do @(negedge clk); while (!src_hdr_ready[s]);
        @(posedge clk);
        src_hdr_valid[s] <= 1'b0;
        for (int i = 0; i < n; i++) begin
            src_pay_valid[s] <= 1'b1;
            src_pay[s]       <= build_beat(seed, i, n);
            do @(negedge clk); while (!src_pay_ready[s]);
            @(posedge clk);
        end
        src_pay_valid[s] <= 1'b0;
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        do @(negedge clk); while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_empty(input string what);
        if (expected.size() != 0) begin
            errors++;
            $display("%s left %0d transfers undelivered at %0t", what, expected.size(), $time);
            expected.delete();
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        rerr;
        logic [2:0]  ctrl;
        clk      = 1'b0;
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        bp_on   <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            src_hdr_valid[i] <= 1'b0;
            src_hdr[i]       <= '0;
            src_pay_valid[i] <= 1'b0;
            src_pay[i]       <= '0;
        end
        fork
            watch_sinks();
        join_none
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        apb_access(1'b0, ADDR_CTRL, '0, rdata, rerr);
        if (rdata !== 32'd7) begin
            report_mismatch("prdata ctrl", 160'(32'd7), 160'(rdata));
        end
        if (rerr !== 1'b0) begin
            report_mismatch("pslverr ctrl", 160'(1'b0), 160'(rerr));
        end
        apb_access(1'b0, 8'h20, '0, rdata, rerr);
        if (rdata !== 32'd0) begin
            report_mismatch("prdata unmapped", 160'(32'd0), 160'(rdata));
        end
        if (rerr !== 1'b1) begin
            report_mismatch("pslverr unmapped", 160'(1'b1), 160'(rerr));
        end

        // Receive routing and drops with rx_udp under back-pressure
        ctrl = 3'b111;
        bp_on <= 1'b1;
        foreach (FRAMES[j]) begin
            if (ctrl[FRAMES[j].route] != FRAMES[j].en) begin
                ctrl[FRAMES[j].route] = FRAMES[j].en;
                apb_access(1'b1, ADDR_CTRL, {29'd0, ctrl}, rdata, rerr);
            end
            if (FRAMES[j].en) begin
                expect_frame(int'(FRAMES[j].route), FRAMES[j], FRAMES[j].seed);
                exp_cnt[FRAMES[j].route]++;
            end else begin
                exp_cnt[3]++;
            end
            send_frame(3, FRAMES[j], FRAMES[j].seed);
            check_empty($sformatf("Receive frame %0d", j));
        end

        for (int r = 0; r < 4; r++) begin
            apb_access(1'b0, cnt_addr[r], '0, rdata, rerr);
            if (rdata !== 32'(exp_cnt[r])) begin
                report_mismatch({"prdata ", cnt_name[r]}, 160'(exp_cnt[r]), 160'(rdata));
            end
        end

        // All three transmit sources offered on the same edge
        expect_frame(3, FRAMES[1], FRAMES[1].seed ^ TX_MIX);
        expect_frame(3, FRAMES[0], FRAMES[0].seed ^ TX_MIX);
        expect_frame(3, FRAMES[2], FRAMES[2].seed ^ TX_MIX);
        fork
            send_frame(0, FRAMES[1], FRAMES[1].seed ^ TX_MIX);
            send_frame(1, FRAMES[0], FRAMES[0].seed ^ TX_MIX);
            send_frame(2, FRAMES[2], FRAMES[2].seed ^ TX_MIX);
        join
        check_empty("Transmit merge");

        repeat (2) @(posedge clk);
        $display("Frames sent: %0d, errors: %0d", N_FRAMES + 3, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verification
hdl/ip_switch_pkg.sv
hdl/ip_rx_demux.sv
hdl/ip_tx_arbiter.sv
hdl/ip_switch_regs.sv
hdl/ip_proto_switch.sv
verification/ip_proto_switch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module ip_proto_switch_tb -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || exit 1
exit 0
